//--- bench/wrb_bank_tb.sv
// Write-response bank testbench with random traffic, reference model and checker

`timescale 1ns/100ps
`include "wrb_config.svh"

module wrb_bank_tb;
  import wrb_pkg::*;

  localparam int NumSlots     = `WRB_NUM_SLOTS;
  localparam int ClkPeriod    = 10;
  localparam int ResetCycles  = 16;
  localparam int RandomCycles = 3000;
  localparam int QuietCycles  = 40;
  localparam int DrainLimit   = 400;
  localparam int TimeoutNs    =
      ClkPeriod * (ResetCycles + RandomCycles + QuietCycles + 3 * DrainLimit) + 1000;

  // Expected front of one identifier's filled queue
  typedef struct packed {
    logic      found;
    wrb_msg_t  msg;
    wrb_addr_t addr;
  } expect_t;

  logic           clk;
  logic           rst_n;
  wrb_id_t        reserve_id_i;
  logic           reserve_ready_i;
  logic           reserve_valid_o;
  wrb_addr_t      reserved_addr_o;
  logic           in_valid_i;
  wrb_msg_t       in_msg_i;
  logic           in_ready_o;
  wrb_slot_mask_t release_en_i;
  wrb_slot_mask_t released_slot_o;
  logic           out_ready_i;
  logic           out_valid_o;
  wrb_msg_t       out_msg_o;

  integer seed;
  int     error_count;
  bit     quiet;

  // Reference model with one entry per slot
  bit       slot_valid_m [NumSlots];
  bit       slot_filled_m [NumSlots];
  wrb_id_t  slot_id_m [NumSlots];
  int       slot_seq_m [NumSlots];
  wrb_msg_t slot_msg_m [NumSlots];
  int       seq_count;

  wrb_clock_gen #(
    .HalfPeriod  (ClkPeriod / 2),
    .ResetCycles (ResetCycles)
  ) u_clock_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  wrb_bank dut0 (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .reserve_id_i    (reserve_id_i),
    .reserve_ready_i (reserve_ready_i),
    .reserve_valid_o (reserve_valid_o),
    .reserved_addr_o (reserved_addr_o),
    .in_valid_i      (in_valid_i),
    .in_msg_i        (in_msg_i),
    .in_ready_o      (in_ready_o),
    .release_en_i    (release_en_i),
    .released_slot_o (released_slot_o),
    .out_ready_i     (out_ready_i),
    .out_valid_o     (out_valid_o),
    .out_msg_o       (out_msg_o)
  );

  //////////////////////////////////////////////////
  // Reference functions
  //////////////////////////////////////////////////

  function automatic int lowest_free_slot();
    for (int s = 0; s < NumSlots; s++) begin
      if (!slot_valid_m[s]) begin
        return s;
      end
    end
    return -1;
  endfunction

  // Oldest reserved slot of an identifier that is filled or still waiting for data
  function automatic int oldest_slot(input wrb_id_t id, input bit filled);
    int best;
    best = -1;
    for (int s = 0; s < NumSlots; s++) begin
      if (slot_valid_m[s] && slot_filled_m[s] == filled && slot_id_m[s] == id) begin
        if (best < 0 || slot_seq_m[s] < slot_seq_m[best]) begin
          best = s;
        end
      end
    end
    return best;
  endfunction

  function automatic expect_t expected_release(input wrb_id_t id);
    expect_t e;
    int      s;
    e = '0;
    s = oldest_slot(id, 1'b1);
    if (s >= 0) begin
      e.found = 1'b1;
      e.msg = slot_msg_m[s];
      e.addr = wrb_addr_t'(s);
    end
    return e;
  endfunction

  function automatic int count_slots(input bit unfilled_only);
    int n;
    n = 0;
    for (int s = 0; s < NumSlots; s++) begin
      if (slot_valid_m[s] && !(unfilled_only && slot_filled_m[s])) begin
        n++;
      end
    end
    return n;
  endfunction

  function automatic int find_unfilled_id(input int start);
    int id;
    for (int k = 0; k < NumIds; k++) begin
      id = (start + k) % NumIds;
      if (oldest_slot(wrb_id_t'(id), 1'b0) >= 0) begin
        return id;
      end
    end
    return -1;
  endfunction

  //////////////////////////////////////////////////
  // Error reporting
  //////////////////////////////////////////////////

  task automatic report_value(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
    error_count++;
    $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, expected);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic report_failure(input string what);
    error_count++;
    $display("ERROR at %0t ns: %s", $time, what);
    $display("Checks failed");
    $fatal(1);
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  // Mostly fills an identifier that has a waiting reservation
  task automatic drive_fill();
    int       r;
    int       id;
    wrb_msg_t msg;
    r = $random(seed);
    id = find_unfilled_id(int'(r[3:0]));
    msg.payload = $random(seed);
    if (id >= 0 && r[7:4] != 4'h0) begin
      msg.id = wrb_id_t'(id);
      in_valid_i <= 1'b1;
    end else begin
      msg.id = r[11:8];
      in_valid_i <= r[12];
    end
    in_msg_i <= msg;
  endtask

  task automatic random_cycle();
    int r;
    r = $random(seed);
    reserve_ready_i <= r[0];
    reserve_id_i <= r[8] ? r[7:4] : {2'b00, r[5:4]};
    out_ready_i <= (r[11:10] != 2'b00);
    release_en_i <= wrb_slot_mask_t'($random(seed) | $random(seed));
    drive_fill();
  endtask

  task automatic drain_all();
    while (count_slots(1'b0) != 0) begin
      @(posedge clk);
      reserve_ready_i <= 1'b0;
      release_en_i <= '1;
      out_ready_i <= ($random(seed) & 3) != 0;
      drive_fill();
    end
  endtask

  initial begin : stimulus
    seed = 32'h8531;
    error_count = 0;
    quiet = 1'b0;
    reserve_id_i <= '0;
    reserve_ready_i <= 1'b0;
    in_valid_i <= 1'b0;
    in_msg_i <= '0;
    release_en_i <= '0;
    out_ready_i <= 1'b0;
    wait (rst_n === 1'b1);

    repeat (RandomCycles) begin
      @(posedge clk);
      random_cycle();
    end
    drain_all();

    // Reserve past a full bank and fill with every release enable low
    @(posedge clk);
    quiet = 1'b1;
    release_en_i <= '0;
    repeat (NumSlots + 4) begin
      reserve_ready_i <= 1'b1;
      reserve_id_i <= wrb_id_t'($random(seed) & 3);
      out_ready_i <= ($random(seed) & 1) != 0;
      drive_fill();
      @(posedge clk);
    end
    reserve_ready_i <= 1'b0;
    while (count_slots(1'b1) != 0) begin
      drive_fill();
      @(posedge clk);
    end
    repeat (QuietCycles) begin
      in_valid_i <= 1'b0;
      out_ready_i <= ($random(seed) & 1) != 0;
      @(posedge clk);
    end
    quiet = 1'b0;
    release_en_i <= '1;
    drain_all();

    repeat (2) @(posedge clk);
    if (error_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  //////////////////////////////////////////////////
  // Comparing process
  //////////////////////////////////////////////////

  initial begin : compare
    int             free_slot;
    int             fill_slot;
    logic           rsv_hs;
    logic           fill_hs;
    logic           out_hs;
    logic           exp_ready;
    expect_t        front;
    wrb_slot_mask_t exp_released;
    logic           prev_valid;
    logic           prev_ready;
    wrb_msg_t       prev_msg;
    wrb_slot_mask_t prev_release_en;

    seq_count = 0;
    for (int s = 0; s < NumSlots; s++) begin
      slot_valid_m[s] = 1'b0;
      slot_filled_m[s] = 1'b0;
    end
    prev_valid = 1'b0;
    prev_ready = 1'b0;
    prev_msg = '0;
    prev_release_en = '0;

    wait (rst_n === 1'b1);
    assert (out_valid_o === 1'b0) else report_value("out_valid_o", out_valid_o, 0);
    assert (released_slot_o === '0) else report_value("released_slot_o", released_slot_o, 0);
    assert (reserve_valid_o === 1'b1) else report_value("reserve_valid_o", reserve_valid_o, 1);

    forever begin
      @(negedge clk);
      free_slot = lowest_free_slot();
      assert (reserve_valid_o === (free_slot >= 0))
        else report_value("reserve_valid_o", reserve_valid_o, free_slot >= 0);
      rsv_hs = reserve_valid_o && reserve_ready_i;
      if (rsv_hs) begin
        assert (reserved_addr_o === wrb_addr_t'(free_slot))
          else report_value("reserved_addr_o", reserved_addr_o, free_slot);
      end

      fill_slot = oldest_slot(in_msg_i.id, 1'b0);
      exp_ready = in_valid_i && (fill_slot >= 0);
      assert (in_ready_o === exp_ready) else report_value("in_ready_o", in_ready_o, exp_ready);
      fill_hs = in_valid_i && in_ready_o;

      // Held output under back-pressure
      if (prev_valid && !prev_ready) begin
        assert (out_valid_o === 1'b1) else report_value("out_valid_o", out_valid_o, 1);
        assert (out_msg_o === prev_msg) else report_value("out_msg_o", out_msg_o, prev_msg);
      end
      if (quiet) begin
        assert (out_valid_o === 1'b0) else report_value("out_valid_o", out_valid_o, 0);
      end

      front = '0;
      out_hs = out_valid_o && out_ready_i;
      if (out_valid_o === 1'b1) begin
        front = expected_release(out_msg_o.id);
        assert (front.found) else report_failure($sformatf(
            "output shows id %0d with no filled response in the model", out_msg_o.id));
        assert (out_msg_o === front.msg) else report_value("out_msg_o", out_msg_o, front.msg);
        // Newly loaded this edge
        if (!prev_valid || prev_ready) begin
          assert (prev_release_en[front.addr] === 1'b1) else report_failure($sformatf(
              "slot %0d was loaded while its release enable was low", front.addr));
        end
      end
      exp_released = out_hs ? (wrb_slot_mask_t'(1) << front.addr) : '0;
      assert (released_slot_o === exp_released)
        else report_value("released_slot_o", released_slot_o, exp_released);

      // Apply this cycle's handshakes to the model
      if (rsv_hs) begin
        slot_valid_m[free_slot] = 1'b1;
        slot_filled_m[free_slot] = 1'b0;
        slot_id_m[free_slot] = reserve_id_i;
        slot_seq_m[free_slot] = seq_count;
        seq_count++;
      end
      if (fill_hs) begin
        slot_filled_m[fill_slot] = 1'b1;
        slot_msg_m[fill_slot] = in_msg_i;
      end
      if (out_hs) begin
        slot_valid_m[front.addr] = 1'b0;
      end

      prev_valid = out_valid_o;
      prev_ready = out_ready_i;
      prev_msg = out_msg_o;
      prev_release_en = release_en_i;
    end
  end

  // Watchdog sized from the test lengths
  initial begin : watchdog
    #(TimeoutNs);
    $display("Timeout: the run did not finish within %0d ns", TimeoutNs);
    $display("Checks failed");
    $fatal(1);
  end

endmodule

//--- bench/wrb_clock_gen.sv
// Testbench clock and reset source for the write-response bank

`timescale 1ns/100ps

module wrb_clock_gen #(
  parameter int HalfPeriod  = 5,
  parameter int ResetCycles = 16
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(HalfPeriod) clk_o = ~clk_o;
  end

  // Release away from the rising edge
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

//--- flist.f
+incdir+rtl
rtl/wrb_pkg.sv
rtl/wrb_slot_store.sv
rtl/wrb_free_slots.sv
rtl/wrb_id_queues.sv
rtl/wrb_release_arbiter.sv
rtl/wrb_bank.sv
bench/wrb_clock_gen.sv
bench/wrb_bank_tb.sv

//--- rtl/wrb_bank.sv
// Write-response bank top: slot allocation, per-identifier lists and ordered release

`timescale 1ns/100ps
`include "wrb_config.svh"

module wrb_bank (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  wrb_pkg::wrb_id_t        reserve_id_i,
  input  logic                    reserve_ready_i,
  output logic                    reserve_valid_o,
  output wrb_pkg::wrb_addr_t      reserved_addr_o,
  input  logic                    in_valid_i,
  input  wrb_pkg::wrb_msg_t       in_msg_i,
  output logic                    in_ready_o,
  input  wrb_pkg::wrb_slot_mask_t release_en_i,
  output wrb_pkg::wrb_slot_mask_t released_slot_o,
  input  logic                    out_ready_i,
  output logic                    out_valid_o,
  output wrb_pkg::wrb_msg_t       out_msg_o
);
  import wrb_pkg::*;

  logic                   any_free;
  logic                   reserve_hs;
  logic                   release_hs;
  logic                   fill_ok;
  wrb_addr_t              free_addr;
  wrb_addr_t              fill_addr;
  wrb_addr_t              out_addr;
  wrb_addr_t [NumIds-1:0] tails;
  logic [NumIds-1:0]      filled;
  wrb_release_t           load;

  // Handshakes
  assign reserve_hs = any_free & reserve_ready_i;
  assign release_hs = out_valid_o & out_ready_i;

  assign reserve_valid_o = any_free;
  assign reserved_addr_o = free_addr;
  assign in_ready_o = fill_ok;

  wrb_free_slots u_free_slots (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .reserve_i       (reserve_hs),
    .release_i       (release_hs),
    .release_addr_i  (out_addr),
    .free_addr_o     (free_addr),
    .any_free_o      (any_free),
    .released_slot_o (released_slot_o)
  );

  wrb_id_queues u_id_queues (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .reserve_i    (reserve_hs),
    .reserve_id_i (reserve_id_i),
    .free_addr_i  (free_addr),
    .fill_valid_i (in_valid_i),
    .fill_id_i    (in_msg_i.id),
    .fill_ok_o    (fill_ok),
    .fill_addr_o  (fill_addr),
    .load_i       (load),
    .tails_o      (tails),
    .filled_o     (filled)
  );

  wrb_release_arbiter u_release_arbiter (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .tails_i      (tails),
    .filled_i     (filled),
    .release_en_i (release_en_i),
    .out_ready_i  (out_ready_i),
    .load_o       (load),
    .out_valid_o  (out_valid_o),
    .out_addr_o   (out_addr)
  );

  // Message store, written on input acceptance, read at the output slot
  wrb_slot_store #(
    .entry_t (wrb_msg_t)
  ) u_msg_store (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .we_i      (fill_ok),
    .waddr_i   (fill_addr),
    .wdata_i   (in_msg_i),
    .raddr_a_i (out_addr),
    .rdata_a_o (out_msg_o),
    .raddr_b_i (out_addr),
    .rdata_b_o ()
  );

endmodule

//--- rtl/wrb_config.svh
// Write-response bank sizing macros shared by the package and the RTL units

`ifndef WRB_CONFIG_SVH
`define WRB_CONFIG_SVH

// Identifier width of a response, 16 identifiers
`define WRB_ID_WIDTH 4

// Payload bits carried next to the identifier
`define WRB_PAYLOAD_WIDTH 28

// Shared slots, common to all identifier lists
`define WRB_NUM_SLOTS 16

`endif

//--- rtl/wrb_free_slots.sv
// Slot occupancy tracking with lowest-free-slot search and freed-slot pulse

`timescale 1ns/100ps
`include "wrb_config.svh"

module wrb_free_slots (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    reserve_i,
  input  logic                    release_i,
  input  wrb_pkg::wrb_addr_t      release_addr_i,
  output wrb_pkg::wrb_addr_t      free_addr_o,
  output logic                    any_free_o,
  output wrb_pkg::wrb_slot_mask_t released_slot_o
);
  import wrb_pkg::*;

  wrb_slot_mask_t valid_q;
  wrb_slot_mask_t valid_d;
  wrb_slot_mask_t reserve_mask;

  //////////////////////////////////////////////////
  // Lowest free slot
  //////////////////////////////////////////////////

  // Scan downwards so the lowest free index wins
  always_comb begin
    free_addr_o = '0;
    for (int i = `WRB_NUM_SLOTS - 1; i >= 0; i--) begin
      if (!valid_q[i]) begin
        free_addr_o = wrb_addr_t'(i);
      end
    end
  end

  assign any_free_o = ~&valid_q;

  //////////////////////////////////////////////////
  // Valid bits
  //////////////////////////////////////////////////

  assign reserve_mask = reserve_i ? (wrb_slot_mask_t'(1) << free_addr_o) : '0;

  // Freed slot pulses only during the output handshake
  assign released_slot_o = release_i ? (wrb_slot_mask_t'(1) << release_addr_i) : '0;

  // A reserved slot is free and a released one is valid, so the masks never overlap
  assign valid_d = (valid_q | reserve_mask) & ~released_slot_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else begin
      valid_q <= valid_d;
    end
  end

endmodule

//--- rtl/wrb_id_queues.sv
// Per-identifier slot lists with head, fill and tail pointers over a next-pointer store

`timescale 1ns/100ps
`include "wrb_config.svh"

module wrb_id_queues (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  logic                                     reserve_i,
  input  wrb_pkg::wrb_id_t                         reserve_id_i,
  input  wrb_pkg::wrb_addr_t                       free_addr_i,
  input  logic                                     fill_valid_i,
  input  wrb_pkg::wrb_id_t                         fill_id_i,
  output logic                                     fill_ok_o,
  output wrb_pkg::wrb_addr_t                       fill_addr_o,
  input  wrb_pkg::wrb_release_t                    load_i,
  output wrb_pkg::wrb_addr_t [wrb_pkg::NumIds-1:0] tails_o,
  output logic [wrb_pkg::NumIds-1:0]               filled_o
);
  import wrb_pkg::*;

  // Counts run up to the full slot count
  localparam int CntWidth = $clog2(`WRB_NUM_SLOTS + 1);

  typedef logic [CntWidth-1:0] cnt_t;

  // Head is the newest reserved slot, fill the oldest unfilled one,
  // tail the oldest filled slot not yet in the output register
  wrb_addr_t head_q [NumIds];
  wrb_addr_t fill_q [NumIds];
  wrb_addr_t tail_q [NumIds];
  cnt_t      rsv_cnt_q [NumIds];
  cnt_t      done_cnt_q [NumIds];

  logic      link_we;
  wrb_addr_t fill_next;
  wrb_addr_t tail_next;

  //////////////////////////////////////////////////
  // Next-pointer store
  //////////////////////////////////////////////////

  // Link the old head to the new slot unless the list is empty
  assign link_we = reserve_i &&
      (rsv_cnt_q[reserve_id_i] != '0 || done_cnt_q[reserve_id_i] != '0);

  wrb_slot_store #(
    .entry_t (wrb_addr_t)
  ) u_next_store (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .we_i      (link_we),
    .waddr_i   (head_q[reserve_id_i]),
    .wdata_i   (free_addr_i),
    .raddr_a_i (fill_q[fill_id_i]),
    .rdata_a_o (fill_next),
    .raddr_b_i (load_i.addr),
    .rdata_b_o (tail_next)
  );

  // Input side
  assign fill_ok_o = fill_valid_i && (rsv_cnt_q[fill_id_i] != '0);
  assign fill_addr_o = fill_q[fill_id_i];

  //////////////////////////////////////////////////
  // Per-identifier pointers
  //////////////////////////////////////////////////

  for (genvar i = 0; i < NumIds; i++) begin : g_id
    logic      rsv_hit;
    logic      fill_hit;
    logic      load_hit;
    wrb_addr_t head_d;
    wrb_addr_t fill_d;
    wrb_addr_t tail_d;
    cnt_t      rsv_cnt_d;
    cnt_t      done_cnt_d;

    assign rsv_hit = reserve_i && (reserve_id_i == wrb_id_t'(i));
    assign fill_hit = fill_ok_o && (fill_id_i == wrb_id_t'(i));
    assign load_hit = load_i.valid && (load_i.id == wrb_id_t'(i));

    always_comb begin
      head_d = rsv_hit ? free_addr_i : head_q[i];
      rsv_cnt_d = rsv_cnt_q[i] + cnt_t'(rsv_hit) - cnt_t'(fill_hit);
      done_cnt_d = done_cnt_q[i] + cnt_t'(fill_hit) - cnt_t'(load_hit);

      // Fill pointer follows its link, or takes the new slot once it
      // has caught up with the head
      fill_d = fill_q[i];
      if (fill_hit && rsv_cnt_q[i] > cnt_t'(1)) begin
        fill_d = fill_next;
      end else if (rsv_hit && (rsv_cnt_q[i] == '0 || fill_hit)) begin
        fill_d = free_addr_i;
      end

      // Tail follows its link, or the slot being filled when nothing
      // else is waiting
      tail_d = tail_q[i];
      if (load_hit && done_cnt_q[i] > cnt_t'(1)) begin
        tail_d = tail_next;
      end else if (fill_hit && (done_cnt_q[i] == '0 || load_hit)) begin
        tail_d = fill_q[i];
      end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        head_q[i] <= '0;
        fill_q[i] <= '0;
        tail_q[i] <= '0;
        rsv_cnt_q[i] <= '0;
        done_cnt_q[i] <= '0;
      end else begin
        head_q[i] <= head_d;
        fill_q[i] <= fill_d;
        tail_q[i] <= tail_d;
        rsv_cnt_q[i] <= rsv_cnt_d;
        done_cnt_q[i] <= done_cnt_d;
      end
    end

    assign tails_o[i] = tail_q[i];
    assign filled_o[i] = |done_cnt_q[i];
  end

endmodule

//--- rtl/wrb_pkg.sv
// Write-response bank types: identifiers, slot addresses, messages and release choice

`include "wrb_config.svh"

package wrb_pkg;

  // Derived sizes
  localparam int NumIds = 2 ** `WRB_ID_WIDTH;
  localparam int SlotAddrWidth = $clog2(`WRB_NUM_SLOTS);

  typedef logic [`WRB_ID_WIDTH-1:0] wrb_id_t;
  typedef logic [SlotAddrWidth-1:0] wrb_addr_t;

  // One bit per shared slot
  typedef logic [`WRB_NUM_SLOTS-1:0] wrb_slot_mask_t;

  // Stored response, identifier in the upper bits
  typedef struct packed {
    wrb_id_t                       id;
    logic [`WRB_PAYLOAD_WIDTH-1:0] payload;
  } wrb_msg_t;

  // Next response to move into the output register
  typedef struct packed {
    logic      valid;
    wrb_id_t   id;
    wrb_addr_t addr;
  } wrb_release_t;

endpackage

//--- rtl/wrb_release_arbiter.sv
// Release arbiter: picks the lowest eligible identifier and holds the output slot

`timescale 1ns/100ps
`include "wrb_config.svh"

module wrb_release_arbiter (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  wrb_pkg::wrb_addr_t [wrb_pkg::NumIds-1:0] tails_i,
  input  logic [wrb_pkg::NumIds-1:0]               filled_i,
  input  wrb_pkg::wrb_slot_mask_t                  release_en_i,
  input  logic                                     out_ready_i,
  output wrb_pkg::wrb_release_t                    load_o,
  output logic                                     out_valid_o,
  output wrb_pkg::wrb_addr_t                       out_addr_o
);
  import wrb_pkg::*;

  logic [NumIds-1:0] eligible;
  logic              can_load;
  logic              out_valid_q;
  wrb_addr_t         out_addr_q;

  // Oldest filled slot of an identifier, gated by its enable bit
  for (genvar i = 0; i < NumIds; i++) begin : g_elig
    assign eligible[i] = filled_i[i] && release_en_i[tails_i[i]];
  end

  // Output register empty or emptied this cycle
  assign can_load = !out_valid_q || out_ready_i;

  always_comb begin
    load_o = '0;
    for (int i = NumIds - 1; i >= 0; i--) begin
      if (eligible[i]) begin
        load_o.id = wrb_id_t'(i);
        load_o.addr = tails_i[i];
      end
    end
    load_o.valid = can_load && (|eligible);
  end

  //////////////////////////////////////////////////
  // Output register
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_valid_q <= 1'b0;
    end else if (can_load) begin
      out_valid_q <= load_o.valid;
    end
  end

  // Address held under back-pressure
  always_ff @(posedge clk_i) begin
    if (load_o.valid) begin
      out_addr_q <= load_o.addr;
    end
  end

  assign out_valid_o = out_valid_q;
  assign out_addr_o = out_addr_q;

endmodule

//--- rtl/wrb_slot_store.sv
// Flop-array slot store with one write port and two asynchronous read ports

`timescale 1ns/100ps
`include "wrb_config.svh"

module wrb_slot_store #(
  parameter type entry_t = wrb_pkg::wrb_addr_t
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               we_i,
  input  wrb_pkg::wrb_addr_t waddr_i,
  input  entry_t             wdata_i,
  input  wrb_pkg::wrb_addr_t raddr_a_i,
  output entry_t             rdata_a_o,
  input  wrb_pkg::wrb_addr_t raddr_b_i,
  output entry_t             rdata_b_o
);
  import wrb_pkg::*;

  entry_t mem_q [`WRB_NUM_SLOTS];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `WRB_NUM_SLOTS; i++) begin
        mem_q[i] <= '0;
      end
    end else if (we_i) begin
      mem_q[waddr_i] <= wdata_i;
    end
  end

  // Reads see the array as it stands before the edge
  assign rdata_a_o = mem_q[raddr_a_i];
  assign rdata_b_o = mem_q[raddr_b_i];

endmodule
